// ==== design/opn_clk_gen.sv ====
// Internal clock enable divider and operator slot counter giving the sample pulse
`timescale 1ns/1ps

module opn_clk_gen
    import opn_pkg::*;
(
    input  logic clk,
    input  logic rst,
    output logic clk_en,
    output logic zero
);

    logic [CEN_W-1:0]  div_cnt;
    logic [SLOT_W-1:0] slot;

    // Master clock divider
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            clk_en  <= 1'b0;
        end else begin
            if (div_cnt == CEN_W'(CEN_DIV - 1)) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            clk_en <= (div_cnt == CEN_W'(CEN_DIV - 1));
        end
    end

    // Operator slot sequence, one step per enable
    always_ff @(posedge clk) begin
        if (rst) begin
            slot <= '0;
        end else if (clk_en) begin
            if (slot == SLOT_W'(SLOTS - 1)) begin
                slot <= '0;
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

    // Start of sample, slot 0
    assign zero = clk_en && (slot == '0);

endmodule

// ==== design/opn_host_if.sv ====
// CPU bus write decoder with timer registers, busy flag, status byte and interrupt
`timescale 1ns/1ps

module opn_host_if
    import opn_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        clk_en,
    input  bus_byte_t   din,
    input  logic [1:0]  addr,
    input  logic        cs_n,
    input  logic        wr_n,
    output bus_byte_t   dout,
    output logic        irq_n,
    opn_timer_if.host   ta,
    opn_timer_if.host   tb
);

    logic              write;
    logic              addr_wr;
    logic              data_wr;

    bus_byte_t         reg_num;     // Latched register number
    logic [7:0]        ta_hi;       // Timer A bits 9..2
    logic [1:0]        ta_lo;       // Timer A bits 1..0
    tb_value_t         tb_val;

    logic              load_a;
    logic              load_b;
    logic              en_a;
    logic              en_b;
    logic              clr_a;
    logic              clr_b;

    logic              busy;
    logic [BUSY_W-1:0] busy_cnt;

    // Bank 1 writes are ignored
    assign write   = !cs_n && !wr_n && !addr[1];
    assign addr_wr = write && !addr[0];
    assign data_wr = write && addr[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_num <= '0;
        end else if (addr_wr) begin
            reg_num <= din;
        end
    end

    // Timer registers
    always_ff @(posedge clk) begin
        if (rst) begin
            ta_hi  <= '0;
            ta_lo  <= '0;
            tb_val <= '0;
            load_a <= 1'b0;
            load_b <= 1'b0;
            en_a   <= 1'b0;
            en_b   <= 1'b0;
        end else if (data_wr) begin
            case (reg_num)
                REG_TA_HI: ta_hi  <= din;
                REG_TA_LO: ta_lo  <= din[1:0];
                REG_TB:    tb_val <= din;
                REG_CTL: begin
                    load_a <= din[CTL_LOAD_A];
                    load_b <= din[CTL_LOAD_B];
                    en_a   <= din[CTL_EN_A];
                    en_b   <= din[CTL_EN_B];
                end
                default: ;  // Not a timer register
            endcase
        end
    end

    // Flag clear strobes, high for one clock only
    always_ff @(posedge clk) begin
        if (rst) begin
            clr_a <= 1'b0;
            clr_b <= 1'b0;
        end else begin
            clr_a <= data_wr && (reg_num == REG_CTL) && din[CTL_CLR_A];
            clr_b <= data_wr && (reg_num == REG_CTL) && din[CTL_CLR_B];
        end
    end

    // Busy window after every data write
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy     <= 1'b1;   // Restarts when already busy
            busy_cnt <= '0;
        end else if (busy && clk_en) begin
            if (busy_cnt == BUSY_W'(BUSY_TICKS - 1)) begin
                busy <= 1'b0;
            end
            busy_cnt <= busy_cnt + 1'b1;
        end
    end

    assign ta.value    = {ta_hi, ta_lo};
    assign ta.load     = load_a;
    assign ta.irq_en   = en_a;
    assign ta.clr_flag = clr_a;

    assign tb.value    = tb_val;
    assign tb.load     = load_b;
    assign tb.irq_en   = en_b;
    assign tb.clr_flag = clr_b;

    // Status byte is always on the bus
    assign dout  = {busy, 5'b00000, tb.flag, ta.flag};
    assign irq_n = !(ta.flag || tb.flag);

endmodule

// ==== design/opn_pkg.sv ====
// FM sound chip timer block constants, register map and shared types
package opn_pkg;

    typedef logic [9:0] ta_value_t;     // Timer A counter
    typedef logic [7:0] tb_value_t;     // Timer B counter
    typedef logic [7:0] bus_byte_t;     // CPU data bus

    // Clocking and pacing
    localparam int CEN_DIV    = 6;      // Master clocks per internal enable
    localparam int SLOTS      = 24;     // 6 channels x 4 operators
    localparam int BUSY_TICKS = 32;     // Enables the busy flag holds
    localparam int TB_DIV     = 16;     // Samples per timer B count

    localparam int CEN_W  = $clog2(CEN_DIV);
    localparam int SLOT_W = $clog2(SLOTS);
    localparam int BUSY_W = $clog2(BUSY_TICKS);

    // Timer register numbers in bank 0
    localparam bus_byte_t REG_TA_HI = 8'h24;   // Timer A bits 9..2
    localparam bus_byte_t REG_TA_LO = 8'h25;   // Timer A bits 1..0
    localparam bus_byte_t REG_TB    = 8'h26;
    localparam bus_byte_t REG_CTL   = 8'h27;

    // Bit positions in REG_CTL
    localparam int CTL_LOAD_A = 0;
    localparam int CTL_LOAD_B = 1;
    localparam int CTL_EN_A   = 2;      // Flag enable, timer A
    localparam int CTL_EN_B   = 3;
    localparam int CTL_CLR_A  = 4;      // Write 1 to clear flag A
    localparam int CTL_CLR_B  = 5;

endpackage

// ==== design/opn_timer.sv ====
// Up-counting sample timer with reload on overflow, prescaler and interrupt flag
`timescale 1ns/1ps

module opn_timer #(
    parameter type value_t  = logic [7:0],
    parameter int  TICK_DIV = 1             // Samples per count
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       zero,
    opn_timer_if.timer tm
);

    localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PRE_W-1:0] pre;
    logic             pre_last;
    logic             tick;
    logic             load_d;
    logic             load_rise;
    logic             overflow;
    value_t           cnt;

    assign pre_last = (pre == PRE_W'(TICK_DIV - 1));

    // Prescaler restarts whenever the timer is stopped
    always_ff @(posedge clk) begin
        if (rst) begin
            pre <= '0;
        end else if (!tm.load) begin
            pre <= '0;
        end else if (zero) begin
            pre <= pre_last ? '0 : pre + 1'b1;
        end
    end

    assign tick      = tm.load && zero && pre_last;
    assign load_rise = tm.load && !load_d;
    assign overflow  = tick && !load_rise && (cnt == '1);

    always_ff @(posedge clk) begin
        if (rst) begin
            load_d <= 1'b0;
            cnt    <= '0;
        end else begin
            load_d <= tm.load;
            if (load_rise || overflow) begin
                cnt <= tm.value;    // Start, or reload so the period repeats
            end else if (tick) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Clear strobe wins over a coincident overflow
    always_ff @(posedge clk) begin
        if (rst) begin
            tm.flag <= 1'b0;
        end else if (tm.clr_flag) begin
            tm.flag <= 1'b0;
        end else if (overflow && tm.irq_en) begin
            tm.flag <= 1'b1;
        end
    end

endmodule

// ==== design/opn_timer_if.sv ====
// Link between the host register block and one timer: value, control and flag
`timescale 1ns/1ps

interface opn_timer_if #(
    parameter type value_t = logic [7:0]
) ();

    value_t value;      // Reload value
    logic   load;       // Counter runs while high
    logic   irq_en;     // Overflow sets the flag
    logic   clr_flag;   // One clock pulse
    logic   flag;

    modport host (
        output value,
        output load,
        output irq_en,
        output clr_flag,
        input  flag
    );

    modport timer (
        input  value,
        input  load,
        input  irq_en,
        input  clr_flag,
        output flag
    );

endinterface

// ==== design/opn_timer_top.sv ====
// Top level of the FM chip host side: bus decoder, clock enables and timers A and B
`timescale 1ns/1ps

module opn_timer_top
    import opn_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  bus_byte_t  din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output bus_byte_t  dout,
    output logic       irq_n,
    output logic       snd_sample
);

    logic clk_en;
    logic zero;     // One pulse per sample

    opn_timer_if #(.value_t(ta_value_t)) ta_bus ();
    opn_timer_if #(.value_t(tb_value_t)) tb_bus ();

    opn_clk_gen u_clk (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .clk_en ( clk_en ),
        .zero   ( zero   )
    );

    opn_host_if u_host (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .clk_en ( clk_en ),
        .din    ( din    ),
        .addr   ( addr   ),
        .cs_n   ( cs_n   ),
        .wr_n   ( wr_n   ),
        .dout   ( dout   ),
        .irq_n  ( irq_n  ),
        .ta     ( ta_bus ),
        .tb     ( tb_bus )
    );

    opn_timer #(.value_t(ta_value_t), .TICK_DIV(1)) u_timer_a (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .zero   ( zero   ),
        .tm     ( ta_bus )
    );

    // Timer B counts once every TB_DIV samples
    opn_timer #(.value_t(tb_value_t), .TICK_DIV(TB_DIV)) u_timer_b (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .zero   ( zero   ),
        .tm     ( tb_bus )
    );

    assign snd_sample = zero;

endmodule

// ==== tb.f ====
design/opn_pkg.sv
design/opn_timer_if.sv
design/opn_clk_gen.sv
design/opn_host_if.sv
design/opn_timer.sv
design/opn_timer_top.sv
tb/opn_timer_properties.sv
tb/tb_opn_timer_top.sv

// ==== tb/opn_timer_properties.sv ====
// Assertions on interrupt output, busy flag and flag clearing of the timer block
`timescale 1ns/1ps

module opn_timer_properties
    import opn_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input bus_byte_t  din,
    input logic [1:0] addr,
    input logic       cs_n,
    input logic       wr_n,
    input bus_byte_t  reg_num,
    input logic       busy,
    input logic       irq_n,
    input logic       flag_a,
    input logic       flag_b
);

    logic data_wr;
    logic ctl_wr;

    assign data_wr = !cs_n && !wr_n && (addr == 2'b01);   // Bank 0 data write
    assign ctl_wr  = data_wr && (reg_num == REG_CTL);

    irq_follows_flags: assert property (@(posedge clk) disable iff (rst)
        irq_n == !(flag_a || flag_b))
        else $error("irq_n does not match the timer flags");

    busy_after_write: assert property (@(posedge clk) disable iff (rst)
        data_wr |=> busy)
        else $error("busy not set after a data write");

    clear_a_drops_flag: assert property (@(posedge clk) disable iff (rst)
        (ctl_wr && din[CTL_CLR_A]) |-> ##[1:2] !flag_a)
        else $error("flag A not cleared");

    clear_b_drops_flag: assert property (@(posedge clk) disable iff (rst)
        (ctl_wr && din[CTL_CLR_B]) |-> ##[1:2] !flag_b)
        else $error("flag B not cleared");

endmodule

// ==== tb/tb_opn_timer_top.sv ====
// Testbench for the FM chip host side: bus writes, busy flag, timers A and B
`timescale 1ns/1ps

module tb_opn_timer_top
    import opn_pkg::*;
();

    localparam int SAMPLE_CLKS = CEN_DIV * SLOTS;       // 144 clocks per sample
    localparam int MAX_A       = 24;                    // Longest timer A period, samples
    localparam int MAX_B       = 6 * TB_DIV;            // Longest timer B period, samples
    localparam int BUSY_MAX    = BUSY_TICKS * CEN_DIV + CEN_DIV;
    localparam int TEST_CYCLES = 16 + BUSY_MAX
                               + 2 * SAMPLE_CLKS            // Sample pulse spacing
                               + 3 * MAX_A * SAMPLE_CLKS    // Timer A, two flags plus slack
                               + 2 * MAX_B * SAMPLE_CLKS    // Timer B, two periods
                               + 2 * MAX_A * SAMPLE_CLKS    // Enable off
                               + 2 * MAX_A * SAMPLE_CLKS    // Write decoding
                               + 30 * BUSY_MAX;             // Register writes and busy waits
    localparam int CYCLE_LIMIT = TEST_CYCLES * 6 / 5;

    logic       clk;
    logic       rst;
    bus_byte_t  din;
    logic [1:0] addr;
    logic       cs_n;
    logic       wr_n;
    bus_byte_t  dout;
    logic       irq_n;
    logic       snd_sample;

    int         err_count;
    int         check_count;
    int         cycle_count;
    logic [31:0] lcg_state;

    // Model state used by the compare process
    logic       model_busy;
    logic       model_fa;
    logic       model_fb;
    event       compare_ev;

    opn_timer_top dut_i (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .din        ( din        ),
        .addr       ( addr       ),
        .cs_n       ( cs_n       ),
        .wr_n       ( wr_n       ),
        .dout       ( dout       ),
        .irq_n      ( irq_n      ),
        .snd_sample ( snd_sample )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, a test did not finish", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected status byte from busy and flag state
    function automatic bus_byte_t expect_status(input logic busy, input logic fb, input logic fa);
        return {busy, 5'b00000, fb, fa};
    endfunction

    task automatic check(input string name, input integer got, input integer exp);
        check_count++;
        if (got !== exp) begin
            $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
            err_count++;
        end
    endtask

    // Compares DUT outputs with the model on request
    always begin
        @(compare_ev);
        check("dout", dout, expect_status(model_busy, model_fb, model_fa));
        check("irq_n", irq_n, !(model_fa || model_fb));
    end

    task automatic compare_status(input logic busy, input logic fb, input logic fa);
        model_busy = busy;
        model_fb   = fb;
        model_fa   = fa;
        ->compare_ev;
        #0;
    endtask

    // One bus cycle; returns 1 ns after the capturing edge
    task automatic bus_write(input logic [1:0] a, input bus_byte_t d);
        @(posedge clk);
        #1;
        addr = a;
        din  = d;
        cs_n = 1'b0;
        wr_n = 1'b0;
        @(posedge clk);
        #1;
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic write_reg(input logic bank, input bus_byte_t num, input bus_byte_t d);
        bus_write({bank, 1'b0}, num);
        bus_write({bank, 1'b1}, d);
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (dout[7] && n < BUSY_MAX + 4) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (dout[7]) begin
            $display("Busy flag stuck high at %0t", $time);
            err_count++;
        end
    endtask

    // Counts samples until the flag bit is set, gives -1 if it never is
    task automatic count_to_flag(input int bit_idx, input int max_samples, output int samples);
        int n;
        n = 0;
        samples = -1;
        while (n <= max_samples) begin
            @(posedge clk);
            #1;
            if (snd_sample) n++;
            if (dout[bit_idx]) begin
                samples = n;
                break;
            end
        end
    endtask

    task automatic check_period(input string name, input int got, input int exp);
        if (got < 0) begin
            $display("Timer flag %s never set at %0t", name, $time);
            err_count++;
        end else begin
            check(name, (got >= exp - 1 && got <= exp + 1) ? exp : got, exp);
        end
    endtask

    task automatic report(input string name, input int errs_before);
        if (err_count == errs_before) $display("Test %s: ok", name);
        else $display("Test %s: %0d errors", name, err_count - errs_before);
    endtask

    task automatic stop_timers();
        write_reg(1'b0, REG_CTL, 8'h30);
        wait_not_busy();
        compare_status(1'b0, 1'b0, 1'b0);
    endtask

    initial begin
        int        e0;
        int        n;
        int        got;
        int        per;
        ta_value_t va;
        tb_value_t vb;

        rst = 1'b1;
        din = '0;
        addr = '0;
        cs_n = 1'b1;
        wr_n = 1'b1;
        err_count = 0;
        check_count = 0;
        cycle_count = 0;
        lcg_state = 32'hd333;
        model_busy = 1'b0;
        model_fa = 1'b0;
        model_fb = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // After reset
        e0 = err_count;
        @(posedge clk);
        #1;
        compare_status(1'b0, 1'b0, 1'b0);
        report("reset", e0);

        // Sample pulse, one clock wide every SAMPLE_CLKS clocks
        e0 = err_count;
        n = 0;
        while (!snd_sample && n <= SAMPLE_CLKS) begin
            @(posedge clk);
            #1;
            n++;
        end
        check("snd_sample", snd_sample, 1);
        @(posedge clk);
        #1;
        check("snd_sample_width", snd_sample, 0);
        n = 1;
        while (!snd_sample && n <= SAMPLE_CLKS) begin
            @(posedge clk);
            #1;
            n++;
        end
        check("snd_sample_spacing", n, SAMPLE_CLKS);
        report("sample", e0);

        // Busy window
        e0 = err_count;
        write_reg(1'b0, 8'h30, 8'h00);
        check("busy", dout[7], 1);
        n = 0;
        while (dout[7] && n < BUSY_MAX) begin
            @(posedge clk);
            #1;
            n++;
        end
        check("busy_fall", dout[7], 0);
        report("busy", e0);

        // Timer A
        e0 = err_count;
        lcg_state = lcg_next(lcg_state);
        va  = ta_value_t'(1000 + lcg_state[23:8] % 24);
        per = 1024 - va;
        write_reg(1'b0, REG_TA_HI, va[9:2]);
        write_reg(1'b0, REG_TA_LO, {6'b0, va[1:0]});
        write_reg(1'b0, REG_CTL, 8'h05);            // Load A, enable A
        count_to_flag(0, per + 2, got);
        check_period("period_a", got, per);
        wait_not_busy();
        compare_status(1'b0, 1'b0, 1'b1);
        write_reg(1'b0, REG_CTL, 8'h15);            // Clear A, keep running
        repeat (2) @(posedge clk);
        #1;
        check("flag_a_clr", dout[0], 0);
        check("irq_n_clr", irq_n, 1);
        count_to_flag(0, per + 2, got);
        check_period("reload_a", got, per);
        stop_timers();
        report("timer_a", e0);

        // Timer B
        e0 = err_count;
        lcg_state = lcg_next(lcg_state);
        vb  = tb_value_t'(250 + lcg_state[23:8] % 6);
        per = (256 - vb) * TB_DIV;
        write_reg(1'b0, REG_TB, vb);
        write_reg(1'b0, REG_CTL, 8'h0a);            // Load B, enable B
        count_to_flag(1, per + 2, got);
        check_period("period_b", got, per);
        wait_not_busy();
        compare_status(1'b0, 1'b1, 1'b0);
        write_reg(1'b0, REG_CTL, 8'h2a);            // Clear B, keep running
        repeat (2) @(posedge clk);
        #1;
        check("flag_b_clr", dout[1], 0);
        check("irq_n_clr", irq_n, 1);
        count_to_flag(1, per + 2, got);
        check_period("reload_b", got, per);
        stop_timers();
        report("timer_b", e0);

        // Load without enable
        e0 = err_count;
        write_reg(1'b0, REG_TA_HI, 8'hff);
        write_reg(1'b0, REG_TA_LO, 8'h00);          // Period 4 samples
        write_reg(1'b0, REG_CTL, 8'h01);
        count_to_flag(0, 2 * 4, got);
        check("no_flag_a", got, -1);
        compare_status(1'b0, 1'b0, 1'b0);
        stop_timers();
        report("enable_off", e0);

        // Second bank and foreign registers are ignored
        e0 = err_count;
        va  = ta_value_t'(1010);
        per = 1024 - va;
        write_reg(1'b0, REG_TA_HI, va[9:2]);
        write_reg(1'b0, REG_TA_LO, {6'b0, va[1:0]});
        wait_not_busy();
        write_reg(1'b1, REG_TA_HI, 8'h00);
        write_reg(1'b1, REG_CTL, 8'h05);
        repeat (2) @(posedge clk);
        #1;
        compare_status(1'b0, 1'b0, 1'b0);
        write_reg(1'b0, 8'h28, 8'h00);
        write_reg(1'b0, 8'h23, 8'h00);
        write_reg(1'b0, REG_CTL, 8'h05);
        count_to_flag(0, per + 2, got);
        check_period("period_decode", got, per);
        stop_timers();
        report("decode", e0);

        $display("Checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

bind opn_timer_top opn_timer_properties u_props (
    .clk     ( clk            ),
    .rst     ( rst            ),
    .din     ( din            ),
    .addr    ( addr           ),
    .cs_n    ( cs_n           ),
    .wr_n    ( wr_n           ),
    .reg_num ( u_host.reg_num ),
    .busy    ( dout[7]        ),
    .irq_n   ( irq_n          ),
    .flag_a  ( ta_bus.flag    ),
    .flag_b  ( tb_bus.flag    )
);
